// ==== files.f ====
source/fetch_pkg.sv
source/imem_apb.sv
source/if_reg.sv
source/insn_predecode.sv
source/fetch_top.sv
tb/fetch_chk.sv
tb/fetch_tb.sv

// ==== source/fetch_pkg.sv ====
// ######################################
// Fetch front end shared types
// Instruction views, decode fields, APB
// ######################################
package fetch_pkg;

    typedef logic [31:0] word_t;                 // Data or address word

    // Register-register layout of an instruction
    typedef struct packed {
        logic [6:0] funct7;                      // Upper function bits
        logic [4:0] rs2;                         // Second source register
        logic [4:0] rs1;                         // First source register
        logic [2:0] funct3;                      // Minor function code
        logic [4:0] rd;                          // Destination register
        logic [6:0] opcode;                      // Major opcode
    } r_view_t;

    // Register-immediate layout of the same word
    typedef struct packed {
        logic [11:0] imm12;                      // 12-bit immediate
        logic [4:0]  rs1;                        // Base or source register
        logic [2:0]  funct3;                     // Minor function code
        logic [4:0]  rd;                         // Destination register
        logic [6:0]  opcode;                     // Major opcode
    } i_view_t;

    typedef union packed {
        r_view_t r_view;                         // R-type decoding
        i_view_t i_view;                         // I-type decoding
    } insn_u;

    typedef enum logic [1:0] {
        fmt_r     = 2'd0,                        // Register-register ALU
        fmt_i     = 2'd1,                        // Immediate, load, jalr
        fmt_s     = 2'd2,                        // Store
        fmt_other = 2'd3                         // Anything else
    } fmt_e;

    typedef struct packed {
        fmt_e       fmt;                         // Format class
        logic [4:0] rd;                          // Destination register
        logic [4:0] rs1;                         // First source register
        logic [4:0] rs2;                         // Second source register
        word_t      imm;                         // Sign-extended immediate
        logic       valid;                       // Stage holds a live insn
    } id_fields_t;

    typedef struct packed {
        logic  psel;                             // Slave selected
        logic  penable;                          // Access phase
        logic  pwrite;                           // Write when high
        word_t paddr;                            // Byte address
        word_t pwdata;                           // Write data
    } apb_req_t;

    typedef struct packed {
        word_t prdata;                           // Read data
        logic  pready;                           // Transfer complete
        logic  pslverr;                          // Range or alignment fault
    } apb_rsp_t;

    localparam word_t isa_nop = 32'h0000_0013;   // addi x0 x0 0

endpackage

// ==== source/fetch_top.sv ====
// ######################################
// Instruction fetch front end top level
// ######################################
`timescale 1ns/1ps

module fetch_top #(
    parameter int IMEM_DEPTH = 256                   // Instruction words
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  fetch_pkg::apb_req_t   apb_req,           // Host load port
    input  logic                  stall,             // Hold the front end
    input  logic                  flush,             // Squash and redirect
    input  logic                  br_taken,          // Branch resolved taken
    input  fetch_pkg::word_t      new_pc,            // Flush target
    input  fetch_pkg::word_t      br_addr,           // Branch target
    output fetch_pkg::apb_rsp_t   apb_rsp,           // Host response
    output fetch_pkg::word_t      if_pc,             // Current PC
    output fetch_pkg::word_t      if_pc_plus4,       // Next sequential PC
    output fetch_pkg::word_t      if_insn,           // IF/ID instruction
    output fetch_pkg::id_fields_t id_fields          // Pre-decoded fields
);
    import fetch_pkg::*;

    word_t fetch_insn;                               // Memory to IF/ID
    logic  if_en;                                    // IF/ID valid flag

    imem_apb #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) u_imem (
        .clk        (clk),
        .arst_n     (arst_n),
        .apb_req    (apb_req),
        .fetch_pc   (if_pc),                         // PC is the fetch address
        .apb_rsp    (apb_rsp),
        .fetch_insn (fetch_insn)
    );

    if_reg u_if_reg (
        .clk         (clk),
        .arst_n      (arst_n),
        .stall       (stall),
        .flush       (flush),
        .br_taken    (br_taken),
        .new_pc      (new_pc),
        .br_addr     (br_addr),
        .fetch_insn  (fetch_insn),
        .if_pc       (if_pc),
        .if_pc_plus4 (if_pc_plus4),
        .if_insn     (if_insn),
        .if_en       (if_en)
    );

    insn_predecode u_predecode (
        .if_insn   (if_insn),
        .if_en     (if_en),
        .id_fields (id_fields)                       // Same cycle as if_insn
    );

endmodule

// ==== source/if_reg.sv ====
// ######################################
// Program counter and IF/ID register
// ######################################
`timescale 1ns/1ps

module if_reg (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             stall,                 // Hold everything
    input  logic             flush,                 // Squash and redirect
    input  logic             br_taken,              // Branch resolved taken
    input  fetch_pkg::word_t new_pc,                // Flush target
    input  fetch_pkg::word_t br_addr,               // Branch target
    input  fetch_pkg::word_t fetch_insn,            // Word from memory
    output fetch_pkg::word_t if_pc,                 // PC and fetch address
    output fetch_pkg::word_t if_pc_plus4,           // Next sequential PC
    output fetch_pkg::word_t if_insn,               // Latched instruction
    output logic             if_en                  // Latched insn is live
);
    import fetch_pkg::*;

    assign if_pc_plus4 = if_pc + 32'd4;

    // Priority is stall then flush then branch
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            if_pc   <= '0;                          // Boot from address zero
            if_insn <= isa_nop;
            if_en   <= 1'b0;
        end
        else if (!stall)
        begin
            if (flush)
            begin
                if_pc   <= new_pc;                  // Redirect
                if_insn <= isa_nop;                 // Bubble into decode
                if_en   <= 1'b0;
            end
            else if (br_taken)
            begin
                if_pc   <= br_addr;                 // Jump to target
                if_insn <= fetch_insn;              // Current fetch stays valid
                if_en   <= 1'b1;
            end
            else
            begin
                if_pc   <= if_pc_plus4;             // Sequential step
                if_insn <= fetch_insn;
                if_en   <= 1'b1;
            end
        end
    end

endmodule

// ==== source/imem_apb.sv ====
// ######################################
// Instruction memory with APB load port
// and asynchronous fetch read port
// ######################################
`timescale 1ns/1ps

module imem_apb #(
    parameter int IMEM_DEPTH = 256                   // Words in the array
) (
    input  logic                clk,
    input  logic                arst_n,
    input  fetch_pkg::apb_req_t apb_req,             // Host request
    input  fetch_pkg::word_t    fetch_pc,            // Fetch byte address
    output fetch_pkg::apb_rsp_t apb_rsp,             // Slave response
    output fetch_pkg::word_t    fetch_insn           // Word at fetch_pc
);
    import fetch_pkg::*;

    localparam int idx_w = (IMEM_DEPTH > 1) ? $clog2(IMEM_DEPTH) : 1;

    word_t       mem [IMEM_DEPTH];                   // Instruction store
    logic [29:0] apb_word;                           // APB word index
    logic        apb_misalign;                       // Low address bits set
    logic        apb_oor;                            // Index past the array
    logic        apb_err;                            // Either fault
    logic        apb_setup;                          // First transfer cycle
    logic        apb_access;                         // Second transfer cycle
    logic [29:0] fetch_word;                         // Fetch word index
    logic        fetch_oor;                          // Fetch past the array
    logic        pready_q;
    logic        pslverr_q;
    word_t       prdata_q;

    assign apb_word     = apb_req.paddr[31:2];
    assign apb_misalign = |apb_req.paddr[1:0];
    assign apb_oor      = apb_word >= 30'(IMEM_DEPTH);
    assign apb_err      = apb_misalign | apb_oor;
    assign apb_setup    = apb_req.psel & ~apb_req.penable;
    assign apb_access   = apb_req.psel & apb_req.penable;

    // Response flags are set in setup so they show in the access cycle
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pready_q  <= 1'b0;
            pslverr_q <= 1'b0;
        end
        else
        begin
            pready_q  <= apb_setup;                  // No wait states
            pslverr_q <= apb_setup & apb_err;        // Fault flagged with pready
        end
    end

    always_ff @(posedge clk)
    begin
        if (apb_setup && !apb_req.pwrite)
        begin
            prdata_q <= apb_err ? '0 : mem[apb_word[idx_w-1:0]];  // Faulted read gives zero
        end
    end

    always_ff @(posedge clk)
    begin
        if (apb_access && apb_req.pwrite && !apb_err)
        begin
            mem[apb_word[idx_w-1:0]] <= apb_req.pwdata;  // Lands at end of access
        end
    end

    assign apb_rsp.prdata  = prdata_q;
    assign apb_rsp.pready  = pready_q;
    assign apb_rsp.pslverr = pslverr_q;

    // Fetch side ignores the byte offset
    assign fetch_word = fetch_pc[31:2];
    assign fetch_oor  = fetch_word >= 30'(IMEM_DEPTH);
    assign fetch_insn = fetch_oor ? isa_nop : mem[fetch_word[idx_w-1:0]];

endmodule

// ==== source/insn_predecode.sv ====
// ######################################
// Pre-decoder for the IF/ID instruction
// Format class, registers, immediate
// ######################################
`timescale 1ns/1ps

module insn_predecode (
    input  fetch_pkg::word_t     if_insn,           // Latched instruction
    input  logic                 if_en,             // Latched insn is live
    output fetch_pkg::id_fields_t id_fields         // Fields for decode
);
    import fetch_pkg::*;

    localparam logic [6:0] op_reg   = 7'b0110011;   // ALU register-register
    localparam logic [6:0] op_imm   = 7'b0010011;   // ALU immediate
    localparam logic [6:0] op_load  = 7'b0000011;   // Loads
    localparam logic [6:0] op_jalr  = 7'b1100111;   // Indirect jump
    localparam logic [6:0] op_store = 7'b0100011;   // Stores

    insn_u       insn;                              // Two views of one word
    fmt_e        fmt;
    logic [11:0] imm12;                             // Raw immediate bits

    assign insn = if_insn;

    always_comb
    begin
        case (insn.r_view.opcode)
            op_reg:
                fmt = fmt_r;
            op_imm, op_load, op_jalr:
                fmt = fmt_i;
            op_store:
                fmt = fmt_s;
            default:
                fmt = fmt_other;
        endcase
    end

    // S-type splits its immediate around rs2 and rs1
    always_comb
    begin
        case (fmt)
            fmt_i:
                imm12 = insn.i_view.imm12;
            fmt_s:
                imm12 = {insn.r_view.funct7, insn.r_view.rd};
            default:
                imm12 = '0;                         // No immediate
        endcase
    end

    assign id_fields.fmt   = fmt;
    assign id_fields.rd    = insn.i_view.rd;        // Same bits in both views
    assign id_fields.rs1   = insn.i_view.rs1;
    assign id_fields.rs2   = insn.r_view.rs2;       // Raw for every format
    assign id_fields.imm   = {{20{imm12[11]}}, imm12};  // Sign bit is insn bit 31
    assign id_fields.valid = if_en;

endmodule

// ==== tb/fetch_chk.sv ====
// ######################################
// Assertions on the IF/ID register and
// the APB slave of the fetch front end
// ######################################
`timescale 1ns/1ps

module fetch_chk (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                stall,
    input  logic                flush,
    input  fetch_pkg::word_t    if_pc,
    input  fetch_pkg::word_t    if_insn,
    input  logic                if_en,
    input  fetch_pkg::apb_req_t apb_req,
    input  fetch_pkg::apb_rsp_t apb_rsp
);

    int fail_cnt = 0;                               // Failed assertions so far

    // Flush without stall leaves a bubble behind
    flush_bubble: assert property (@(posedge clk) disable iff (!arst_n)
        (flush && !stall) |=> !if_en)
        else
        begin
            fail_cnt++;
            $error("if_en set after a flush");
        end

    stall_hold: assert property (@(posedge clk) disable iff (!arst_n)
        stall |=> ($stable(if_pc) && $stable(if_insn) && $stable(if_en)))
        else
        begin
            fail_cnt++;
            $error("IF/ID outputs moved during a stall");
        end

    // Zero wait states on every access cycle
    access_ready: assert property (@(posedge clk) disable iff (!arst_n)
        (apb_req.psel && apb_req.penable) |-> apb_rsp.pready)
        else
        begin
            fail_cnt++;
            $error("APB access cycle without pready");
        end

endmodule

// The top level is where if_reg and imem_apb signals meet
bind fetch_top fetch_chk chk0 (
    .clk     (clk),
    .arst_n  (arst_n),
    .stall   (stall),
    .flush   (flush),
    .if_pc   (if_pc),
    .if_insn (if_insn),
    .if_en   (if_en),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp)
);

// ==== tb/fetch_tb.sv ====
// ######################################
// Testbench for the fetch front end
// ######################################
`timescale 1ns/1ps

module fetch_tb;
    import fetch_pkg::*;

    localparam int imem_depth = 256;
    localparam int wd_cycles  = 10 + 140 * 3 + 40 + 300 + 10 + 120;  // Budgets plus margin

    typedef struct packed {
        word_t      pc;                             // Expected PC
        word_t      insn;                           // Expected IF/ID word
        id_fields_t fields;                         // Expected decode, valid inside
    } model_t;

    localparam logic [6:0] op_tab [8] = '{7'h33, 7'h13, 7'h03, 7'h67,
                                          7'h23, 7'h6f, 7'h37, 7'h63};

    logic       clk;
    logic       arst_n;
    apb_req_t   apb_req;
    apb_rsp_t   apb_rsp;
    logic       stall;
    logic       flush;
    logic       br_taken;
    word_t      new_pc;
    word_t      br_addr;
    word_t      if_pc;
    word_t      if_pc_plus4;
    word_t      if_insn;
    id_fields_t id_fields;

    word_t      model_mem [imem_depth];             // Mirror of the DUT array
    model_t     exp_st;                             // Reference state
    logic [15:0] lfsr;
    logic       check_en;
    int         err_count;
    int         err_mark;
    int         tests_ok;
    int         tests_bad;

    fetch_top #(
        .IMEM_DEPTH (imem_depth)
    ) dut0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .apb_req     (apb_req),
        .stall       (stall),
        .flush       (flush),
        .br_taken    (br_taken),
        .new_pc      (new_pc),
        .br_addr     (br_addr),
        .apb_rsp     (apb_rsp),
        .if_pc       (if_pc),
        .if_pc_plus4 (if_pc_plus4),
        .if_insn     (if_insn),
        .id_fields   (id_fields)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;                      // 8 ns period
    end

    // x^16 + x^14 + x^13 + x^11, one step per bit
    function automatic word_t rand_bits(input int n);
        word_t r;
        logic  fb;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic word_t rand_insn();
        word_t w;
        w      = rand_bits(32);
        w[6:0] = op_tab[rand_bits(3)];              // Mix of format classes
        return w;
    endfunction

    // Field split straight from the ISA encoding
    function automatic id_fields_t predecode_ref(input word_t w, input logic v);
        id_fields_t f;
        logic [6:0] op;
        op      = w[6:0];
        f.rd    = w[11:7];
        f.rs1   = w[19:15];
        f.rs2   = w[24:20];
        f.valid = v;
        f.fmt   = fmt_other;
        f.imm   = '0;
        if (op == 7'b0110011)
            f.fmt = fmt_r;
        else if (op == 7'b0010011 || op == 7'b0000011 || op == 7'b1100111)
        begin
            f.fmt = fmt_i;
            f.imm = {{20{w[31]}}, w[31:20]};
        end
        else if (op == 7'b0100011)
        begin
            f.fmt = fmt_s;
            f.imm = {{20{w[31]}}, w[31:25], w[11:7]};
        end
        return f;
    endfunction

    function automatic word_t model_fetch(input word_t pc);
        if (pc[31:2] < imem_depth)
            return model_mem[pc[31:2]];
        return isa_nop;                             // Past the array
    endfunction

    function automatic model_t next_state(input model_t cur, input logic stl, input logic fl,
                                          input logic br, input word_t npc, input word_t bra,
                                          input word_t fetched);
        model_t nxt;
        nxt = cur;
        if (!stl && fl)
        begin
            nxt.pc     = npc;
            nxt.insn   = isa_nop;
            nxt.fields = predecode_ref(isa_nop, 1'b0);
        end
        else if (!stl)
        begin
            nxt.pc     = br ? bra : cur.pc + 32'd4;
            nxt.insn   = fetched;
            nxt.fields = predecode_ref(fetched, 1'b1);
        end
        return nxt;
    endfunction

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp)
        begin
            $display("[FAIL] %s got %h expected %h at %0t", name, got, exp, $time);
            err_count++;
        end
    endtask

    task automatic end_test(input string name);
        if (err_count == err_mark)
        begin
            $display("%s: ok", name);
            tests_ok++;
        end
        else
        begin
            $display("%s: %0d errors", name, err_count - err_mark);
            tests_bad++;
        end
        err_mark = err_count;
    endtask

    task automatic step();
        @(posedge clk);
        #1;                                         // Drive just after the edge
    endtask

    task automatic apb_xfer(input logic wr, input word_t addr, input word_t wdata,
                            output word_t rdata, output logic err);
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        step();
        apb_req.penable = 1'b1;                     // Access cycle
        check_val("pready", apb_rsp.pready, 1'b1);  // No wait states allowed
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        step();                                     // Write lands on this edge
        apb_req = '0;
    endtask

    task automatic apb_write(input word_t addr, input word_t data, output logic err);
        word_t unused;
        apb_xfer(1'b1, addr, data, unused, err);
        if (addr[1:0] == 2'b00 && addr[31:2] < imem_depth)
            model_mem[addr[31:2]] = data;
    endtask

    task automatic apb_read(input word_t addr, output word_t data, output logic err);
        apb_xfer(1'b0, addr, '0, data, err);
    endtask

    // Reference model advances on the same edge as the DUT
    always @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            exp_st <= '{pc: '0, insn: isa_nop, fields: predecode_ref(isa_nop, 1'b0)};
        else
            exp_st <= next_state(exp_st, stall, flush, br_taken, new_pc, br_addr,
                                 model_fetch(exp_st.pc));
    end

    always @(negedge clk)
    begin
        if (arst_n && check_en)
        begin
            check_val("if_pc", if_pc, exp_st.pc);
            check_val("if_pc_plus4", if_pc_plus4, exp_st.pc + 32'd4);
            check_val("if_insn", if_insn, exp_st.insn);
            check_val("id_fields", id_fields, exp_st.fields);
        end
    end

    initial
    begin
        #(wd_cycles * 8);
        $display("Watchdog expired before the tests finished");
        $display("test failed");
        $finish;
    end

    initial
    begin
        word_t w;
        logic  err;
        lfsr      = 16'd29;
        arst_n    = 1'b0;
        apb_req   = '0;
        stall     = 1'b1;                           // Frozen while memory loads
        flush     = 1'b0;
        br_taken  = 1'b0;
        new_pc    = '0;
        br_addr   = '0;
        check_en  = 1'b0;
        err_count = 0;
        err_mark  = 0;
        tests_ok  = 0;
        tests_bad = 0;
        repeat (8) @(posedge clk);
        #1 arst_n = 1'b1;
        check_en  = 1'b1;

        check_val("if_pc", if_pc, '0);
        check_val("if_insn", if_insn, isa_nop);
        check_val("id_fields.valid", id_fields.valid, 1'b0);
        check_val("pready", apb_rsp.pready, 1'b0);
        end_test("reset state");

        for (int i = 0; i < 64; i++)
        begin
            apb_write(word_t'(i * 4), rand_insn(), err);
            check_val("pslverr", err, 1'b0);
        end
        for (int i = 0; i < 64; i++)
        begin
            apb_read(word_t'(i * 4), w, err);
            check_val("prdata", w, model_mem[i]);
            check_val("pslverr", err, 1'b0);
        end
        end_test("apb load and readback");

        apb_write(word_t'(imem_depth * 4), 32'h1234_5678, err);
        check_val("pslverr", err, 1'b1);
        apb_read(word_t'(imem_depth * 4), w, err);
        check_val("pslverr", err, 1'b1);
        check_val("prdata", w, '0);
        apb_write(32'd10, 32'hdead_beef, err);      // Misaligned onto word 2
        check_val("pslverr", err, 1'b1);
        apb_read(32'd10, w, err);
        check_val("pslverr", err, 1'b1);
        apb_read(32'd8, w, err);
        check_val("prdata", w, model_mem[2]);
        check_val("pslverr", err, 1'b0);
        end_test("apb errors");

        stall = 1'b0;
        repeat (40) step();
        stall = 1'b1;
        step();
        end_test("sequential fetch");

        for (int i = 0; i < 300; i++)
        begin
            stall    = (rand_bits(2) == 0);
            flush    = (rand_bits(3) == 0);
            br_taken = (rand_bits(2) == 0) || (if_pc[31:2] >= 30'd56);  // Stay in loaded words
            new_pc   = rand_bits(6) << 2;
            br_addr  = rand_bits(6) << 2;
            step();
        end
        end_test("random control");

        stall    = 1'b0;
        flush    = 1'b0;
        br_taken = 1'b1;
        br_addr  = word_t'(imem_depth * 4 + 16);
        step();
        br_taken = 1'b0;
        step();
        check_val("if_pc", if_pc, word_t'(imem_depth * 4 + 20));
        check_val("if_insn", if_insn, isa_nop);
        check_val("id_fields.valid", id_fields.valid, 1'b1);
        stall = 1'b1;
        step();
        end_test("fetch beyond memory");

        $display("%0d tests ok, %0d tests with errors, %0d check errors, %0d assertion errors",
                 tests_ok, tests_bad, err_count, dut0.chk0.fail_cnt);
        if (err_count == 0 && tests_bad == 0 && dut0.chk0.fail_cnt == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule
